//--- ct_store.sv
`timescale 1ns/1ps

module ct_store #(
    parameter int U_DEPTH = hqc_decap_pkg::U_DEPTH_DEF
) (
    input  logic                      clk,
    input  logic                      ct_wen,
    input  hqc_decap_pkg::ct_field_t  ct_sel,
    input  logic [$clog2(U_DEPTH)-1:0] ct_addr,
    input  hqc_decap_pkg::word_t      ct_wdata,
    input  hqc_decap_pkg::ct_field_t  rd_sel,
    input  logic [$clog2(U_DEPTH)-1:0] rd_addr,
    output hqc_decap_pkg::word_t      rd_word
);

    import hqc_decap_pkg::*;

    localparam int A_W  = $clog2(U_DEPTH);
    localparam int V_AW = $clog2(U_DEPTH - 1);
    localparam int D_AW = $clog2(D_DEPTH);

    logic           u_wen;
    logic           v_wen;
    logic           d_wen;
    logic [A_W-1:0] ram_addr;
    word_t          u_rdata;
    word_t          v_rdata;
    d_word_t        d_rdata;
    ct_field_t      rd_sel_q;

    assign u_wen = ct_wen && (ct_sel == CT_U);
    assign v_wen = ct_wen && (ct_sel == CT_V);
    assign d_wen = ct_wen && (ct_sel == CT_D);

    // host owns the address while writing, the check reads otherwise
    assign ram_addr = ct_wen ? ct_addr : rd_addr;

    ct_word_ram #(.word_type(word_t), .DEPTH(U_DEPTH)) u_ram (
        .clk   (clk),
        .wen   (u_wen),
        .addr  (ram_addr),
        .wdata (ct_wdata),
        .rdata (u_rdata)
    );

    ct_word_ram #(.word_type(word_t), .DEPTH(U_DEPTH - 1)) v_ram (
        .clk   (clk),
        .wen   (v_wen),
        .addr  (ram_addr[V_AW-1:0]),
        .wdata (ct_wdata),
        .rdata (v_rdata)
    );

    ct_word_ram #(.word_type(d_word_t), .DEPTH(D_DEPTH)) d_ram (
        .clk   (clk),
        .wen   (d_wen),
        .addr  (ram_addr[D_AW-1:0]),
        .wdata (ct_wdata[D_W-1:0]),
        .rdata (d_rdata)
    );

    // select follows the RAM read latency
    always_ff @(posedge clk) begin
        rd_sel_q <= rd_sel;
    end

    always_comb begin
        case (rd_sel_q)
            CT_U:    rd_word = u_rdata;
            CT_V:    rd_word = v_rdata;
            CT_D:    rd_word = {{(WORD_W - D_W){1'b0}}, d_rdata};
            default: rd_word = '0;
        endcase
    end

endmodule

//--- ct_word_ram.sv
`timescale 1ns/1ps

module ct_word_ram #(
    parameter type word_type = logic [31:0],
    parameter int  DEPTH     = 16
) (
    input  logic                     clk,
    input  logic                     wen,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  word_type                 wdata,
    output word_type                 rdata
);

    word_type mem [DEPTH];

    // read data registered one cycle after the address
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- decap_sequencer.sv
`timescale 1ns/1ps

module decap_sequencer #(
    parameter int U_DEPTH   = hqc_decap_pkg::U_DEPTH_DEF,
    parameter int MSG_BYTES = hqc_decap_pkg::MSG_BYTES_DEF,
    localparam int M_WORDS  = MSG_BYTES / 4,
    localparam int M_AW     = (M_WORDS > 1) ? $clog2(M_WORDS) : 1,
    localparam int A_W      = $clog2(U_DEPTH)
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     dec_done,
    input  logic                     enc_done,
    output logic                     dec_start,
    output logic                     capture,
    output logic                     shift,
    output logic                     enc_m_wen,
    output logic [M_AW-1:0]          enc_m_addr,
    output logic                     enc_start,
    output logic                     enc_out_en,
    output hqc_decap_pkg::ct_field_t rd_sel,
    output logic [A_W-1:0]           rd_addr,
    output logic                     cmp_en,
    output hqc_decap_pkg::ct_field_t cmp_field,
    output logic                     clear,
    output logic                     done
);

    import hqc_decap_pkg::*;

    // the shared counter must reach the longest phase
    localparam int CNT_N = (U_DEPTH > M_WORDS) ? U_DEPTH : M_WORDS;
    localparam int CNT_W = $clog2((CNT_N > D_DEPTH) ? CNT_N : D_DEPTH);

    localparam logic [CNT_W-1:0] M_LAST = CNT_W'(M_WORDS - 1);
    localparam logic [CNT_W-1:0] U_LAST = CNT_W'(U_DEPTH - 1);
    localparam logic [CNT_W-1:0] V_LAST = CNT_W'(U_DEPTH - 2);
    localparam logic [CNT_W-1:0] D_LAST = CNT_W'(D_DEPTH - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_DEC,
        S_FEED,
        S_WAIT_ENC,
        S_CMP_U,
        S_CMP_V,
        S_CMP_D,
        S_DRAIN
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            cnt       <= '0;
            dec_start <= 1'b0;
            done      <= 1'b0;
        end else begin
            dec_start <= 1'b0;
            done      <= 1'b0;
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    if (start) begin
                        dec_start <= 1'b1;
                        state     <= S_WAIT_DEC;
                    end
                end
                S_WAIT_DEC: begin
                    if (dec_done) begin
                        state <= S_FEED;
                    end
                end
                S_FEED: begin
                    if (cnt == M_LAST) begin
                        cnt   <= '0;
                        state <= S_WAIT_ENC;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_WAIT_ENC: begin
                    if (enc_done) begin
                        state <= S_CMP_U;
                    end
                end
                S_CMP_U: begin
                    if (cnt == U_LAST) begin
                        cnt   <= '0;
                        state <= S_CMP_V;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_CMP_V: begin
                    if (cnt == V_LAST) begin
                        cnt   <= '0;
                        state <= S_CMP_D;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_CMP_D: begin
                    if (cnt == D_LAST) begin
                        cnt   <= '0;
                        state <= S_DRAIN;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // last d word is compared here, the flag settles for done
                S_DRAIN: begin
                    done  <= 1'b1;
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign clear   = (state == S_IDLE) && start;
    assign capture = (state == S_WAIT_DEC) && dec_done;

    // one message word per feed cycle
    assign enc_m_wen  = state == S_FEED;
    assign shift      = enc_m_wen;
    assign enc_m_addr = cnt[M_AW-1:0];
    assign enc_start  = enc_m_wen && (cnt == M_LAST);

    always_comb begin
        case (state)
            S_CMP_U: rd_sel = CT_U;
            S_CMP_V: rd_sel = CT_V;
            S_CMP_D: rd_sel = CT_D;
            default: rd_sel = CT_NONE;
        endcase
    end

    // encryption core and ciphertext RAMs are read with the same address
    assign rd_addr    = cnt[A_W-1:0];
    assign enc_out_en = rd_sel != CT_NONE;
    assign cmp_en     = enc_out_en;
    assign cmp_field  = rd_sel;

endmodule

//--- hqc_decap.sv
`timescale 1ns/1ps

module hqc_decap #(
    parameter int U_DEPTH   = hqc_decap_pkg::U_DEPTH_DEF,
    parameter int MSG_BYTES = hqc_decap_pkg::MSG_BYTES_DEF,
    localparam int M_WORDS  = MSG_BYTES / 4,
    localparam int M_AW     = (M_WORDS > 1) ? $clog2(M_WORDS) : 1,
    localparam int A_W      = $clog2(U_DEPTH)
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          ct_wen,
    input  hqc_decap_pkg::ct_field_t      ct_sel,
    input  logic [A_W-1:0]                ct_addr,
    input  hqc_decap_pkg::word_t          ct_wdata,
    output logic                          dec_start,
    input  logic                          dec_done,
    input  logic [MSG_BYTES*8-1:0]        dec_msg,
    output logic                          enc_m_wen,
    output logic [M_AW-1:0]               enc_m_addr,
    output logic [hqc_decap_pkg::M_W-1:0] enc_m_word,
    output logic                          enc_start,
    input  logic                          enc_done,
    output logic                          enc_out_en,
    output hqc_decap_pkg::ct_field_t      enc_out_sel,
    output logic [A_W-1:0]                enc_out_addr,
    input  hqc_decap_pkg::word_t          enc_dout,
    output logic                          done,
    output logic                          reject
);

    import hqc_decap_pkg::*;

    logic      capture;
    logic      shift;
    logic      cmp_en;
    ct_field_t cmp_field;
    logic      clear;
    word_t     stored_word;

    decap_sequencer #(.U_DEPTH(U_DEPTH), .MSG_BYTES(MSG_BYTES)) u_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .dec_done   (dec_done),
        .enc_done   (enc_done),
        .dec_start  (dec_start),
        .capture    (capture),
        .shift      (shift),
        .enc_m_wen  (enc_m_wen),
        .enc_m_addr (enc_m_addr),
        .enc_start  (enc_start),
        .enc_out_en (enc_out_en),
        .rd_sel     (enc_out_sel),
        .rd_addr    (enc_out_addr),
        .cmp_en     (cmp_en),
        .cmp_field  (cmp_field),
        .clear      (clear),
        .done       (done)
    );

    msg_feeder #(.MSG_BYTES(MSG_BYTES)) u_feeder (
        .clk     (clk),
        .capture (capture),
        .shift   (shift),
        .dec_msg (dec_msg),
        .m_word  (enc_m_word)
    );

    // stored ciphertext read in step with the encryption output
    ct_store #(.U_DEPTH(U_DEPTH)) u_store (
        .clk      (clk),
        .ct_wen   (ct_wen),
        .ct_sel   (ct_sel),
        .ct_addr  (ct_addr),
        .ct_wdata (ct_wdata),
        .rd_sel   (enc_out_sel),
        .rd_addr  (enc_out_addr),
        .rd_word  (stored_word)
    );

    reencrypt_check u_check (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .cmp_en      (cmp_en),
        .cmp_field   (cmp_field),
        .stored_word (stored_word),
        .enc_word    (enc_dout),
        .mismatch    (reject)
    );

endmodule

//--- hqc_decap_pkg.sv
package hqc_decap_pkg;

    // u and v words, also the width of the encryption output bus
    parameter int WORD_W = 128;

    // d is a 512-bit hash held as 32-bit words
    parameter int D_W     = 32;
    parameter int D_DEPTH = 16;

    // message words sent to the encryption core
    parameter int M_W = 32;

    // hqc128 defaults, v always holds one word fewer than u
    parameter int U_DEPTH_DEF   = 139;
    parameter int MSG_BYTES_DEF = 16;

    // ciphertext field select, shared by host writes and encryption reads
    typedef enum logic [1:0] {
        CT_NONE = 2'd0,
        CT_D    = 2'd1,
        CT_U    = 2'd2,
        CT_V    = 2'd3
    } ct_field_t;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [D_W-1:0]    d_word_t;

endpackage

//--- msg_feeder.sv
`timescale 1ns/1ps

module msg_feeder #(
    parameter int MSG_BYTES = hqc_decap_pkg::MSG_BYTES_DEF
) (
    input  logic                         clk,
    input  logic                         capture,
    input  logic                         shift,
    input  logic [MSG_BYTES*8-1:0]       dec_msg,
    output logic [hqc_decap_pkg::M_W-1:0] m_word
);

    import hqc_decap_pkg::*;

    localparam int MSG_W = MSG_BYTES * 8;

    logic [MSG_W-1:0] msg_rev;
    logic [MSG_W-1:0] msg_q;

    // byte 0 of the message lands in the top byte
    always_comb begin
        for (int j = 0; j < MSG_BYTES; j++) begin
            msg_rev[MSG_W-1-8*j -: 8] = dec_msg[8*j +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            msg_q <= msg_rev;
        end else if (shift) begin
            msg_q <= msg_q << M_W;
        end
    end

    // current word is always the top of the register
    assign m_word = msg_q[MSG_W-1 -: M_W];

endmodule

//--- reencrypt_check.sv
`timescale 1ns/1ps

module reencrypt_check (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clear,
    input  logic                     cmp_en,
    input  hqc_decap_pkg::ct_field_t cmp_field,
    input  hqc_decap_pkg::word_t     stored_word,
    input  hqc_decap_pkg::word_t     enc_word,
    output logic                     mismatch
);

    import hqc_decap_pkg::*;

    logic      cmp_en_q;
    ct_field_t cmp_field_q;
    logic      word_diff;

    // line the enable up with data returning one cycle after the address
    always_ff @(posedge clk) begin
        if (rst) begin
            cmp_en_q    <= 1'b0;
            cmp_field_q <= CT_NONE;
        end else begin
            cmp_en_q    <= cmp_en;
            cmp_field_q <= cmp_field;
        end
    end

    // d words only carry D_W valid bits
    always_comb begin
        if (cmp_field_q == CT_D) begin
            word_diff = stored_word[D_W-1:0] != enc_word[D_W-1:0];
        end else begin
            word_diff = stored_word != enc_word;
        end
    end

    // sticky over the whole run, any differing word rejects
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            mismatch <= 1'b0;
        end else if (cmp_en_q && word_diff) begin
            mismatch <= 1'b1;
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_hqc_decap -o tb_hqc_decap \
    && ./obj_dir/tb_hqc_decap > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -qx "TESTS PASSED" sim.log \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }

//--- tb_engine_model.sv
`timescale 1ns/1ps

module tb_engine_model #(
    parameter int U_DEPTH   = hqc_decap_pkg::U_DEPTH_DEF,
    parameter int MSG_BYTES = hqc_decap_pkg::MSG_BYTES_DEF,
    localparam int A_W      = $clog2(U_DEPTH)
) (
    input  logic                     clk,
    input  logic                     rst,
    // host writes are mirrored so the same ciphertext can be served back
    input  logic                     ct_wen,
    input  hqc_decap_pkg::ct_field_t ct_sel,
    input  logic [A_W-1:0]           ct_addr,
    input  hqc_decap_pkg::word_t     ct_wdata,
    // per run settings
    input  logic [MSG_BYTES*8-1:0]   msg_in,
    input  logic [3:0]               dec_delay,
    input  logic [4:0]               enc_delay,
    input  logic                     corrupt_en,
    input  hqc_decap_pkg::ct_field_t corrupt_sel,
    input  logic [A_W-1:0]           corrupt_addr,
    input  hqc_decap_pkg::word_t     corrupt_mask,
    input  logic                     dec_start,
    output logic                     dec_done,
    output logic [MSG_BYTES*8-1:0]   dec_msg,
    input  logic                     enc_start,
    output logic                     enc_done,
    input  logic                     enc_out_en,
    input  hqc_decap_pkg::ct_field_t enc_out_sel,
    input  logic [A_W-1:0]           enc_out_addr,
    output hqc_decap_pkg::word_t     enc_dout
);

    import hqc_decap_pkg::*;

    localparam int D_AW = $clog2(D_DEPTH);

    word_t      u_mem [U_DEPTH];
    word_t      v_mem [U_DEPTH - 1];
    // d keeps the full host word, upper bits are junk on the output bus
    word_t      d_mem [D_DEPTH];
    word_t      served;
    logic       dec_busy;
    logic       enc_busy;
    logic [3:0] dec_cnt;
    logic [4:0] enc_cnt;

    initial begin
        dec_done = 1'b0;
        dec_msg  = '0;
        enc_done = 1'b0;
        enc_dout = '0;
    end

    always @(posedge clk) begin
        if (ct_wen) begin
            case (ct_sel)
                CT_U:    u_mem[ct_addr] <= ct_wdata;
                CT_V:    v_mem[ct_addr] <= ct_wdata;
                CT_D:    d_mem[ct_addr[D_AW-1:0]] <= ct_wdata;
                default: ;
            endcase
        end
    end

    // re-encrypted word, equal to the stored one unless this is the corrupted slot
    always_comb begin
        case (enc_out_sel)
            CT_U:    served = u_mem[enc_out_addr];
            CT_V:    served = v_mem[enc_out_addr];
            CT_D:    served = d_mem[enc_out_addr[D_AW-1:0]];
            default: served = '0;
        endcase
        if (corrupt_en && (enc_out_sel == corrupt_sel) && (enc_out_addr == corrupt_addr)) begin
            served = served ^ corrupt_mask;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            dec_done <= 1'b0;
            dec_msg  <= '0;
            dec_busy <= 1'b0;
            dec_cnt  <= '0;
            enc_done <= 1'b0;
            enc_busy <= 1'b0;
            enc_cnt  <= '0;
            enc_dout <= '0;
        end else begin
            dec_done <= 1'b0;
            dec_msg  <= '0;
            enc_done <= 1'b0;
            if (dec_start) begin
                dec_busy <= 1'b1;
                dec_cnt  <= dec_delay;
            end else if (dec_busy) begin
                if (dec_cnt <= 4'd1) begin
                    dec_busy <= 1'b0;
                    dec_done <= 1'b1;
                    dec_msg  <= msg_in;
                end else begin
                    dec_cnt <= dec_cnt - 4'd1;
                end
            end
            // result ready some cycles after the last message word
            if (enc_start) begin
                enc_busy <= 1'b1;
                enc_cnt  <= enc_delay;
            end else if (enc_busy) begin
                if (enc_cnt <= 5'd1) begin
                    enc_busy <= 1'b0;
                    enc_done <= 1'b1;
                end else begin
                    enc_cnt <= enc_cnt - 5'd1;
                end
            end
            // read data one cycle after the address
            if (enc_out_en) begin
                enc_dout <= served;
            end
        end
    end

endmodule

//--- tb_hqc_decap.sv
`timescale 1ns/1ps

module tb_hqc_decap;

    import hqc_decap_pkg::*;

    localparam int U_DEPTH     = U_DEPTH_DEF;
    localparam int MSG_BYTES   = MSG_BYTES_DEF;
    localparam int MSG_W       = MSG_BYTES * 8;
    localparam int M_WORDS     = MSG_BYTES / 4;
    localparam int M_AW        = (M_WORDS > 1) ? $clog2(M_WORDS) : 1;
    localparam int A_W         = $clog2(U_DEPTH);
    localparam int RUNS        = 8;
    // read cycles after enc_done, u then v then d
    localparam int RD_WORDS    = 2 * U_DEPTH - 1 + D_DEPTH;
    // one run including the worst model delays, and one full ciphertext load
    localparam int RUN_CYCLES  = 2 * U_DEPTH + 16 + 64;
    localparam int LOAD_CYCLES = 2 * U_DEPTH - 1 + D_DEPTH + 2;
    localparam int LIMIT       = RUNS * (RUN_CYCLES + LOAD_CYCLES) + 20;

    logic             clk;
    logic             rst;
    logic             start;
    logic             ct_wen;
    ct_field_t        ct_sel;
    logic [A_W-1:0]   ct_addr;
    word_t            ct_wdata;
    logic             dec_start;
    logic             dec_done;
    logic [MSG_W-1:0] dec_msg;
    logic             enc_m_wen;
    logic [M_AW-1:0]  enc_m_addr;
    logic [M_W-1:0]   enc_m_word;
    logic             enc_start;
    logic             enc_done;
    logic             enc_out_en;
    ct_field_t        enc_out_sel;
    logic [A_W-1:0]   enc_out_addr;
    word_t            enc_dout;
    logic             done;
    logic             reject;
    logic [MSG_W-1:0] msg_in;
    logic [3:0]       dec_delay;
    logic [4:0]       enc_delay;
    logic             corrupt_en;
    ct_field_t        corrupt_sel;
    logic [A_W-1:0]   corrupt_addr;
    word_t            corrupt_mask;
    logic [31:0]      lfsr;
    logic [MSG_W-1:0] cur_msg;
    logic             start_q;
    logic             feeding;
    int               rd_idx;
    int               n_dec_start;
    int               n_done;
    int               feed_idx;
    int               errors;

    hqc_decap #(.U_DEPTH(U_DEPTH), .MSG_BYTES(MSG_BYTES)) uut (
        .clk(clk), .rst(rst), .start(start),
        .ct_wen(ct_wen), .ct_sel(ct_sel), .ct_addr(ct_addr), .ct_wdata(ct_wdata),
        .dec_start(dec_start), .dec_done(dec_done), .dec_msg(dec_msg),
        .enc_m_wen(enc_m_wen), .enc_m_addr(enc_m_addr), .enc_m_word(enc_m_word),
        .enc_start(enc_start), .enc_done(enc_done), .enc_out_en(enc_out_en),
        .enc_out_sel(enc_out_sel), .enc_out_addr(enc_out_addr), .enc_dout(enc_dout),
        .done(done), .reject(reject)
    );

    tb_engine_model #(.U_DEPTH(U_DEPTH), .MSG_BYTES(MSG_BYTES)) engine (
        .clk(clk), .rst(rst),
        .ct_wen(ct_wen), .ct_sel(ct_sel), .ct_addr(ct_addr), .ct_wdata(ct_wdata),
        .msg_in(msg_in), .dec_delay(dec_delay), .enc_delay(enc_delay),
        .corrupt_en(corrupt_en), .corrupt_sel(corrupt_sel),
        .corrupt_addr(corrupt_addr), .corrupt_mask(corrupt_mask),
        .dec_start(dec_start), .dec_done(dec_done), .dec_msg(dec_msg),
        .enc_start(enc_start), .enc_done(enc_done), .enc_out_en(enc_out_en),
        .enc_out_sel(enc_out_sel), .enc_out_addr(enc_out_addr), .enc_dout(enc_dout)
    );

    always #20 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic word_t rand_bits(input int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[WORD_W-2:0], fb};
        end
        return r;
    endfunction

    // word a carries bytes 4a..4a+3, byte 4a most significant
    function automatic logic [M_W-1:0] msg_word(input logic [MSG_W-1:0] m, input int a);
        logic [M_W-1:0] w;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            w = {w[M_W-9:0], m[8 * (4 * a + k) +: 8]};
        end
        return w;
    endfunction

    // field read in compare cycle i after enc_done
    function automatic ct_field_t read_field(input int i);
        if (i < U_DEPTH) begin
            return CT_U;
        end else if (i < 2 * U_DEPTH - 1) begin
            return CT_V;
        end
        return CT_D;
    endfunction

    function automatic int read_addr(input int i);
        if (i < U_DEPTH) begin
            return i;
        end else if (i < 2 * U_DEPTH - 1) begin
            return i - U_DEPTH;
        end
        return i - (2 * U_DEPTH - 1);
    endfunction

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic write_word(input ct_field_t sel, input int addr);
        @(posedge clk);
        ct_wen   <= 1'b1;
        ct_sel   <= sel;
        ct_addr  <= A_W'(addr);
        ct_wdata <= rand_bits(WORD_W);
    endtask

    // fresh random ciphertext, d upper bits are random too and must be ignored
    task automatic load_ct();
        for (int i = 0; i < U_DEPTH; i++) begin
            write_word(CT_U, i);
        end
        for (int i = 0; i < U_DEPTH - 1; i++) begin
            write_word(CT_V, i);
        end
        for (int i = 0; i < D_DEPTH; i++) begin
            write_word(CT_D, i);
        end
        @(posedge clk);
        ct_wen <= 1'b0;
        ct_sel <= CT_NONE;
    endtask

    task automatic run_once(input logic c_en, input ct_field_t c_sel, input int c_addr,
                            input word_t c_mask);
        logic  exp_reject;
        word_t r;
        exp_reject = c_en && ((c_sel == CT_D) ? (c_mask[D_W-1:0] != '0) : (c_mask != '0));
        for (int k = 0; k < M_WORDS; k++) begin
            r = rand_bits(M_W);
            cur_msg[M_W*k +: M_W] = r[M_W-1:0];
        end
        @(posedge clk);
        r = rand_bits(7);
        msg_in       <= cur_msg;
        dec_delay    <= 4'(3 + r[2:0]);
        enc_delay    <= 5'(2 + r[6:3]);
        corrupt_en   <= c_en;
        corrupt_sel  <= c_sel;
        corrupt_addr <= A_W'(c_addr);
        corrupt_mask <= c_mask;
        start        <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!done) begin
            @(posedge clk);
        end
        check("reject", WORD_W'(exp_reject), WORD_W'(reject));
        check("message word count", WORD_W'(M_WORDS), WORD_W'(feed_idx));
        @(posedge clk);
        check("done", '0, WORD_W'(done));
        check("done pulses", WORD_W'(1), WORD_W'(n_done));
    endtask

    // bus monitor, counters restart with each start
    always @(posedge clk) begin
        start_q <= start;
        if (rst || start) begin
            n_dec_start <= 0;
            n_done      <= 0;
            feed_idx    <= 0;
            feeding     <= 1'b0;
            rd_idx      <= -1;
        end else begin
            // decryption is asked for in the cycle after start
            check("dec_start", WORD_W'(start_q), WORD_W'(dec_start));
            if (dec_start) begin
                n_dec_start <= n_dec_start + 1;
            end
            if (dec_done) begin
                check("dec_start pulses", WORD_W'(1), WORD_W'(n_dec_start));
                feeding <= 1'b1;
            end
            if (done) begin
                n_done <= n_done + 1;
            end
            // message words follow dec_done back to back
            check("enc_m_wen", WORD_W'(feeding), WORD_W'(enc_m_wen));
            if (enc_m_wen) begin
                check("enc_m_addr", WORD_W'(feed_idx), WORD_W'(enc_m_addr));
                check("enc_m_word", WORD_W'(msg_word(cur_msg, feed_idx)), WORD_W'(enc_m_word));
                check("enc_start", WORD_W'(feed_idx == M_WORDS - 1), WORD_W'(enc_start));
                feed_idx <= feed_idx + 1;
                if (feed_idx == M_WORDS - 1) begin
                    feeding <= 1'b0;
                end
            end else begin
                check("enc_start", '0, WORD_W'(enc_start));
            end
            if (rd_idx >= 0 && rd_idx < RD_WORDS) begin
                check("enc_out_en", WORD_W'(1), WORD_W'(enc_out_en));
                check("enc_out_sel", WORD_W'(read_field(rd_idx)), WORD_W'(enc_out_sel));
                check("enc_out_addr", WORD_W'(read_addr(rd_idx)), WORD_W'(enc_out_addr));
            end else begin
                check("enc_out_en", '0, WORD_W'(enc_out_en));
            end
            // one drain cycle after the last read, then done
            check("done", WORD_W'(rd_idx == RD_WORDS + 1), WORD_W'(done));
            if (enc_done) begin
                rd_idx <= 0;
            end else if (rd_idx > RD_WORDS) begin
                rd_idx <= -1;
            end else if (rd_idx >= 0) begin
                rd_idx <= rd_idx + 1;
            end
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("watchdog expired before all runs finished, the DUT stopped responding");
        $display("TESTS FAILED");
        $fatal(1, "timeout after %0d cycles", LIMIT);
    end

    initial begin
        word_t mask;
        int    pick;
        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        ct_wen       = 1'b0;
        ct_sel       = CT_NONE;
        ct_addr      = '0;
        ct_wdata     = '0;
        msg_in       = '0;
        dec_delay    = 4'd3;
        enc_delay    = 5'd2;
        corrupt_en   = 1'b0;
        corrupt_sel  = CT_NONE;
        corrupt_addr = '0;
        corrupt_mask = '0;
        cur_msg      = '0;
        errors       = 0;
        lfsr         = 32'hc19f_83b7;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check("done", '0, WORD_W'(done));
        check("reject", '0, WORD_W'(reject));
        check("dec_start", '0, WORD_W'(dec_start));
        check("enc_m_wen", '0, WORD_W'(enc_m_wen));
        check("enc_start", '0, WORD_W'(enc_start));
        check("enc_out_en", '0, WORD_W'(enc_out_en));
        // matching ciphertext
        repeat (3) begin
            load_ct();
            run_once(1'b0, CT_NONE, 0, '0);
        end
        // one corrupted word per field
        load_ct();
        mask = rand_bits(WORD_W) | WORD_W'(1);
        pick = int'(rand_bits(8)) % U_DEPTH;
        run_once(1'b1, CT_U, pick, mask);
        load_ct();
        mask = rand_bits(WORD_W) | WORD_W'(1);
        run_once(1'b1, CT_V, U_DEPTH - 2, mask);
        load_ct();
        mask = rand_bits(D_W) | WORD_W'(1);
        pick = int'(rand_bits(4));
        run_once(1'b1, CT_D, pick, mask);
        // rejecting run then a clean run on the same ciphertext
        mask = rand_bits(WORD_W) | WORD_W'(1);
        pick = int'(rand_bits(8)) % (U_DEPTH - 1);
        run_once(1'b1, CT_V, pick, mask);
        run_once(1'b0, CT_NONE, 0, '0);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
hqc_decap_pkg.sv
ct_word_ram.sv
ct_store.sv
msg_feeder.sv
reencrypt_check.sv
decap_sequencer.sv
hqc_decap.sv
tb_engine_model.sv
tb_hqc_decap.sv
